// File: vlog.f
design/n64advPkg.sv
design/n64VideoDemux.sv
design/colorPath.sv
design/syncPath.sv
design/videoOutFormatter.sv
design/n64advVideoTop.sv
test/tbN64advVideo.sv

// File: Bender.yml
package:
  name: n64adv_video

dependencies: {}

sources:
  # Design, package first
  - design/n64advPkg.sv
  - design/n64VideoDemux.sv
  - design/colorPath.sv
  - design/syncPath.sv
  - design/videoOutFormatter.sv
  - design/n64advVideoTop.sv
  # Testbench
  - target: test
    files:
      - test/tbN64advVideo.sv

// File: test/videoInput.dat
# name jumpers(ypbpr,rgsb,vga,filter) cut nibble(nV,nClamp,nH,nC) r g b
# expected vd_o {c0,c1,c2}, expected syncs {nCsyncAdv,nCsync,nHsyncOrF1,nVsyncOrF2}
rgbBlack    0 0 f 00 00 00 000000 c
rgbWhite    2 0 f 7f 7f 7f ffffff f
rgbMix      2 0 4 40 3f 01 817e02 8
rgbFilter   1 0 0 12 55 6a 24abd5 b
rgbVgaOn    3 0 5 7e 41 3e fd837c c
rgsbSync    6 0 e 2a 15 70 542ae1 3
rgsbNoSync  4 0 1 7f 00 40 ff0081 c
rgsbHsync   6 0 9 01 02 03 020406 d
ypbBlack    a 0 f 00 00 00 800080 f
ypbWhite    8 0 e 7f 7f 7f 80ff80 0
ypbRed      b 0 5 7f 00 00 ff4c55 c
ypbGreen    a 0 7 00 7f 00 15952b e
ypbBlue     8 0 d 00 00 7f 6b1cff c
ypbYellow   e 0 f 7f 7f 00 94e200 f
ypbCyan     c 0 0 00 7f 7f 00b2aa 0
ypbMid      9 0 b 40 20 10 a34f65 f
ypbGray     a 0 6 3f 3f 3f 807e80 2
cutRgb      2 1 3 11 22 33 224466 e
cutYpbpr    a 1 8 00 00 00 800080 1
rgbRepeat   2 0 f 7f 7f 7f ffffff f

// File: test/tbN64advVideo.sv
////////////////////
// Testbench for the N64 video path
// Replays console pixels from a data file and checks
// the DAC bus and sync pins, with timing and hold
////////////////////

`timescale 1ns/1ns
`default_nettype none

module tbN64advVideo;

  import n64advPkg::*;

  localparam int ResetCycles   = 16;
  localparam int CyclesPerTest = 12;
  localparam int PipeEdges     = 4;
  localparam int MaxGap        = 3;
  // DAC bus plus the four sync pins
  localparam int OutW          = 3 * ColorWidthO + 4;

  // One line of the data file, expected pins packed as {vd, syncs}
  typedef struct packed {
    logic [3:0]             jumpers;
    logic                   cut;
    logic [3:0]             nibble;
    logic [ColorWidthI-1:0] r;
    logic [ColorWidthI-1:0] g;
    logic [ColorWidthI-1:0] b;
    logic [OutW-1:0]        expOut;
  } vector_t;

  logic                     vclk;
  logic                     reset;
  logic                     nVdsync;
  logic [ColorWidthI-1:0]   vdIn;
  logic                     enRgsb;
  logic                     enYpbpr;
  logic                     useVgaSync;
  logic                     filterOn;
  logic [3*ColorWidthO-1:0] vdOut;
  logic                     nCsyncAdv;
  logic                     nCsync;
  logic                     nHsyncOrF1;
  logic                     nVsyncOrF2;
  logic [OutW-1:0]          dutOut;

  string                    names[$];
  vector_t                  vectors[$];
  logic [OutW-1:0]          heldOut;
  logic                     loaded;
  int                       passCount;
  int                       failCount;

  n64advVideoTop #(.colorWidthI(ColorWidthI), .colorWidthO(ColorWidthO)) DUT (
    .VCLK_i(vclk), .reset_i(reset), .nVdsync_i(nVdsync), .vd_i(vdIn),
    .enRgsb_i(enRgsb), .enYpbpr_i(enYpbpr), .useVgaSync_i(useVgaSync),
    .filterOn_i(filterOn), .vd_o(vdOut), .nCsyncAdv_o(nCsyncAdv), .nCsync_o(nCsync),
    .nHsyncOrF1_o(nHsyncOrF1), .nVsyncOrF2_o(nVsyncOrF2)
  );

  // Same bit order as the expected column pair
  assign dutOut = {vdOut, nCsyncAdv, nCsync, nHsyncOrF1, nVsyncOrF2};

  // 8 ns VCLK
  always #4 vclk = ~vclk;

  ////////////////////
  // Helpers
  ////////////////////

  task automatic compareOutputs(input string name, input logic [OutW-1:0] expected,
                                inout int bad);
    assert (dutOut === expected) else begin
      $display("MISMATCH %s expected %h actual %h at %0t", name, expected, dutOut, $time);
      bad++;
    end
  endtask

  // Drive one bus word, step one edge, pins must still hold
  task automatic busCycle(input logic nSync, input logic [ColorWidthI-1:0] word,
                          input string name, inout int bad);
    nVdsync = nSync;
    vdIn    = word;
    @(posedge vclk);
    #1;
    compareOutputs(name, heldOut, bad);
  endtask

  // Reads every data line, lines starting with # are skipped
  task automatic loadVectors(output bit ok);
    int      fd;
    int      cnt;
    string   line;
    string   name;
    int      j, c, n, r, g, b, ev, es;
    vector_t v;
    ok = 1'b0;
    fd = $fopen("test/videoInput.dat", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin
          cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h", name, j, c, n, r, g, b, ev, es);
          if (cnt == 9) begin
            v.jumpers = j[3:0];
            v.cut     = c[0];
            v.nibble  = n[3:0];
            v.r       = r[ColorWidthI-1:0];
            v.g       = g[ColorWidthI-1:0];
            v.b       = b[ColorWidthI-1:0];
            v.expOut  = {ev[3*ColorWidthO-1:0], es[3:0]};
            names.push_back(name);
            vectors.push_back(v);
          end else begin
            $display("data file line could not be parsed: %s", line);
            ok = 1'b0;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Black bus and idle syncs straight out of reset
  task automatic checkReset();
    int bad;
    bad = 0;
    compareOutputs("afterReset", heldOut, bad);
    if (bad == 0) begin
      passCount++;
      $display("test afterReset ok");
    end else begin
      failCount++;
      $display("test afterReset FAILED with %0d errors", bad);
    end
  endtask

  task automatic runVector(input string name, input vector_t v);
    int bad;
    int gap;
    bad = 0;
    {enYpbpr, enRgsb, useVgaSync, filterOn} = v.jumpers;
    // Partial pixel with inverted data, cut short by the real sync cycle
    if (v.cut) begin
      busCycle(1'b0, {{(ColorWidthI-4){1'b0}}, ~v.nibble}, name, bad);
      busCycle(1'b1, ~v.r, name, bad);
      busCycle(1'b1, ~v.g, name, bad);
    end
    busCycle(1'b0, {{(ColorWidthI-4){1'b0}}, v.nibble}, name, bad);
    busCycle(1'b1, v.r, name, bad);
    busCycle(1'b1, v.g, name, bad);
    // Returns just after the B-sample edge
    busCycle(1'b1, v.b, name, bad);
    repeat (PipeEdges - 1) busCycle(1'b1, '0, name, bad);
    // New pixel appears on the fourth edge
    @(posedge vclk);
    #1;
    compareOutputs(name, v.expOut, bad);
    heldOut = v.expOut;
    // Idle gap, outputs hold
    gap = $urandom_range(MaxGap, 0);
    repeat (gap) busCycle(1'b1, '0, name, bad);
    if (bad == 0) begin
      passCount++;
      $display("test %s ok", name);
    end else begin
      failCount++;
      $display("test %s FAILED with %0d errors", name, bad);
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin : mainSeq
    bit ok;
    int seedDummy;
    vclk       = 1'b0;
    reset      = 1'b1;
    nVdsync    = 1'b1;
    vdIn       = '0;
    enRgsb     = 1'b0;
    enYpbpr    = 1'b0;
    useVgaSync = 1'b0;
    filterOn   = 1'b0;
    loaded     = 1'b0;
    passCount  = 0;
    failCount  = 0;
    heldOut    = {{(3*ColorWidthO){1'b0}}, 4'hf};
    seedDummy  = $urandom(32'hfb0c128a);
    loadVectors(ok);
    loaded = 1'b1;
    if (!ok || vectors.size() == 0) begin
      $display("data file missing or empty, no test could run");
      $display("sim failed");
      $finish;
    end else begin
      repeat (ResetCycles) @(posedge vclk);
      #1;
      reset = 1'b0;
      checkReset();
      foreach (vectors[i]) runVector(names[i], vectors[i]);
      $display("tests %0d, passed %0d, failed %0d",
               passCount + failCount, passCount, failCount);
      if (failCount == 0) begin
        $display("sim passed");
      end else begin
        $display("sim failed");
      end
      $finish;
    end
  end

  // Budget of 12 cycles per test on top of reset
  initial begin : watchdog
    wait (loaded);
    repeat (ResetCycles + (vectors.size() + 1) * CyclesPerTest) @(posedge vclk);
    $display("timeout, the tests did not complete in the expected number of cycles");
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/n64advVideoTop.sv
////////////////////
// N64 video path top level
// Console bus in, ADV712x bus and sync pins out
////////////////////

`timescale 1ns/1ns
`default_nettype none

module n64advVideoTop #(
  parameter int colorWidthI = n64advPkg::ColorWidthI,
  parameter int colorWidthO = n64advPkg::ColorWidthO
) (
  input  logic                     VCLK_i,
  input  logic                     reset_i,
  input  logic                     nVdsync_i,
  input  logic [colorWidthI-1:0]   vd_i,
  // Jumpers
  input  logic                     enRgsb_i,
  input  logic                     enYpbpr_i,
  input  logic                     useVgaSync_i,
  input  logic                     filterOn_i,
  // DAC and sync pins
  output logic [3*colorWidthO-1:0] vd_o,
  output logic                     nCsyncAdv_o,
  output logic                     nCsync_o,
  output logic                     nHsyncOrF1_o,
  output logic                     nVsyncOrF2_o
);

  import n64advPkg::*;

  pixIn_t    pix;
  colorPix_t color;
  syncOut_t  sync;

  n64VideoDemux #(.colorWidthI(colorWidthI)) demuxU (
    .VCLK_i(VCLK_i), .reset_i(reset_i), .nVdsync_i(nVdsync_i), .vd_i(vd_i), .pix_o(pix)
  );

  // Both paths run side by side on the same pixel
  colorPath #(.colorWidthI(colorWidthI), .colorWidthO(colorWidthO)) colorU (
    .VCLK_i(VCLK_i), .reset_i(reset_i), .enRgsb_i(enRgsb_i), .enYpbpr_i(enYpbpr_i),
    .pix_i(pix), .color_o(color)
  );

  syncPath syncU (
    .VCLK_i(VCLK_i), .reset_i(reset_i), .useVgaSync_i(useVgaSync_i),
    .filterOn_i(filterOn_i), .pix_i(pix), .sync_o(sync)
  );

  videoOutFormatter #(.colorWidthO(colorWidthO)) formatU (
    .VCLK_i(VCLK_i), .reset_i(reset_i), .color_i(color), .sync_i(sync), .vd_o(vd_o),
    .nCsyncAdv_o(nCsyncAdv_o), .nCsync_o(nCsync_o),
    .nHsyncOrF1_o(nHsyncOrF1_o), .nVsyncOrF2_o(nVsyncOrF2_o)
  );

endmodule

`default_nettype wire

// File: design/videoOutFormatter.sv
////////////////////
// Output formatter
// Registers the DAC bus and sync pins per pixel
////////////////////

`timescale 1ns/1ns
`default_nettype none

module videoOutFormatter #(
  parameter int colorWidthO = n64advPkg::ColorWidthO
) (
  input  logic                     VCLK_i,
  input  logic                     reset_i,
  input  n64advPkg::colorPix_t     color_i,
  input  n64advPkg::syncOut_t      sync_i,
  output logic [3*colorWidthO-1:0] vd_o,
  output logic                     nCsyncAdv_o,
  output logic                     nCsync_o,
  output logic                     nHsyncOrF1_o,
  output logic                     nVsyncOrF2_o
);

  import n64advPkg::*;

  logic pixValid;
  logic nCsyncDac;

  assign pixValid = color_i.valid & sync_i.valid;

  // Sync on green only in RGsB and YPbPr
  assign nCsyncDac = (color_i.mode == OUT_RGB) ? 1'b1 : sync_i.nCsync;

  ////////////////////
  // Output registers
  ////////////////////

  // Idle bus is black with all syncs inactive, held between pixels
  always_ff @(posedge VCLK_i) begin
    if (reset_i) begin
      vd_o         <= '0;
      nCsyncAdv_o  <= 1'b1;
      nCsync_o     <= 1'b1;
      nHsyncOrF1_o <= 1'b1;
      nVsyncOrF2_o <= 1'b1;
    end else if (pixValid) begin
      // c0 on the top byte
      vd_o         <= {color_i.c0, color_i.c1, color_i.c2};
      nCsyncAdv_o  <= nCsyncDac;
      nCsync_o     <= sync_i.nCsync;
      nHsyncOrF1_o <= sync_i.nHsyncOrF1;
      nVsyncOrF2_o <= sync_i.nVsyncOrF2;
    end
  end

  // Colour and sync paths stay in lockstep
  assert property (@(posedge VCLK_i) disable iff (reset_i)
    color_i.valid == sync_i.valid);

endmodule

`default_nettype wire

// File: design/syncPath.sv
////////////////////
// Sync path
// Holds the sync nibble of each pixel, delays it in step
// with the colour path and selects the shared pins
////////////////////

`timescale 1ns/1ns
`default_nettype none

module syncPath (
  input  logic                VCLK_i,
  input  logic                reset_i,
  input  logic                useVgaSync_i,
  input  logic                filterOn_i,
  input  n64advPkg::pixIn_t   pix_i,
  output n64advPkg::syncOut_t sync_o
);

  import n64advPkg::*;

  logic      valid1, valid2, valid3;
  syncBits_t sync1, sync2;
  logic      nCsyncQ;
  logic      nHsyncOrF1Q;
  logic      nVsyncOrF2Q;

  // Valid chain, matches colorPath stage count
  always_ff @(posedge VCLK_i) begin
    if (reset_i) begin
      valid1 <= 1'b0;
      valid2 <= 1'b0;
      valid3 <= 1'b0;
    end else begin
      valid1 <= pix_i.valid;
      valid2 <= valid1;
      valid3 <= valid2;
    end
  end

  ////////////////////
  // Nibble pipeline
  ////////////////////

  // Stage 1 captures only on a complete pixel
  always_ff @(posedge VCLK_i) begin
    if (pix_i.valid) begin
      sync1 <= pix_i.sync;
    end
    sync2 <= sync1;
  end

  // Stage 3, VGA sync or filter add-on control on the shared pins
  always_ff @(posedge VCLK_i) begin
    nCsyncQ     <= sync2.nCsync;
    nHsyncOrF1Q <= useVgaSync_i ? sync2.nHsync : filterOn_i;
    nVsyncOrF2Q <= useVgaSync_i ? sync2.nVsync : filterOn_i;
  end

  assign sync_o = '{valid: valid3, nCsync: nCsyncQ,
                    nHsyncOrF1: nHsyncOrF1Q, nVsyncOrF2: nVsyncOrF2Q};

  // Clamp bit of a pixel stays put from its sync cycle up to its B word
  assert property (@(posedge VCLK_i) disable iff (reset_i)
    pix_i.valid |-> (pix_i.sync.nClamp == $past(pix_i.sync.nClamp, 3)));

endmodule

`default_nettype wire

// File: design/colorPath.sv
////////////////////
// Colour path
// Three stages, word expansion, mode decode and
// optional RGB to YPbPr conversion with saturation
////////////////////

`timescale 1ns/1ns
`default_nettype none

module colorPath #(
  parameter int colorWidthI = n64advPkg::ColorWidthI,
  parameter int colorWidthO = n64advPkg::ColorWidthO
) (
  input  logic                 VCLK_i,
  input  logic                 reset_i,
  input  logic                 enRgsb_i,
  input  logic                 enYpbpr_i,
  input  n64advPkg::pixIn_t    pix_i,
  output n64advPkg::colorPix_t color_o
);

  import n64advPkg::*;

  // Room for the signed weighted sums
  localparam int SumW      = colorWidthO + 10;
  localparam int ExpW      = colorWidthO - colorWidthI;
  localparam int CoefShift = 8;
  localparam int Offset    = 1 << (colorWidthO - 1);
  localparam int MaxVal    = (1 << colorWidthO) - 1;

  // Weights scaled by 256
  localparam int CoefYR  = 77;
  localparam int CoefYG  = 150;
  localparam int CoefYB  = 29;
  localparam int CoefPbR = -43;
  localparam int CoefPbG = -85;
  localparam int CoefPbB = 128;
  localparam int CoefPrR = 128;
  localparam int CoefPrG = -107;
  localparam int CoefPrB = -21;

  logic                   valid1, valid2, valid3;
  outMode_e               mode1, mode2, mode3;
  logic [colorWidthO-1:0] r1, g1, b1;
  logic [colorWidthO-1:0] r2, g2, b2;
  logic signed [SumW-1:0] rS, gS, bS;
  logic signed [SumW-1:0] y2, pb2, pr2;
  logic signed [SumW-1:0] yS, pbS, prS;
  logic [colorWidthO-1:0] c0Q, c1Q, c2Q;

  // Clamp to the DAC range
  function automatic logic [colorWidthO-1:0] saturate(input logic signed [SumW-1:0] x);
    logic [colorWidthO-1:0] res;
    if (x < 0) res = '0;
    else if (x > MaxVal) res = colorWidthO'(MaxVal);
    else res = x[colorWidthO-1:0];
    return res;
  endfunction

  // Valid chain, three stages
  always_ff @(posedge VCLK_i) begin
    if (reset_i) begin
      valid1 <= 1'b0;
      valid2 <= 1'b0;
      valid3 <= 1'b0;
    end else begin
      valid1 <= pix_i.valid;
      valid2 <= valid1;
      valid3 <= valid2;
    end
  end

  // Stage 1, mode decode and top bit into the new LSB
  always_ff @(posedge VCLK_i) begin
    mode1 <= enYpbpr_i ? OUT_YPBPR : (enRgsb_i ? OUT_RGSB : OUT_RGB);
    r1    <= {pix_i.r, pix_i.r[colorWidthI-1 -: ExpW]};
    g1    <= {pix_i.g, pix_i.g[colorWidthI-1 -: ExpW]};
    b1    <= {pix_i.b, pix_i.b[colorWidthI-1 -: ExpW]};
  end

  assign rS = SumW'(r1);
  assign gS = SumW'(g1);
  assign bS = SumW'(b1);

  // Stage 2, weighted sums, RGB kept for the bypass
  always_ff @(posedge VCLK_i) begin
    mode2 <= mode1;
    {r2, g2, b2} <= {r1, g1, b1};
    y2  <= SumW'(rS * CoefYR  + gS * CoefYG  + bS * CoefYB);
    pb2 <= SumW'(rS * CoefPbR + gS * CoefPbG + bS * CoefPbB);
    pr2 <= SumW'(rS * CoefPrR + gS * CoefPrG + bS * CoefPrB);
  end

  // Floor shift and chroma offset
  assign yS  = y2 >>> CoefShift;
  assign pbS = SumW'((pb2 >>> CoefShift) + Offset);
  assign prS = SumW'((pr2 >>> CoefShift) + Offset);

  // Stage 3, Pr on the red DAC, Y on green (sync on Y), Pb on blue
  always_ff @(posedge VCLK_i) begin
    mode3 <= mode2;
    if (mode2 == OUT_YPBPR) begin
      c0Q <= saturate(prS);
      c1Q <= saturate(yS);
      c2Q <= saturate(pbS);
    end else begin
      {c0Q, c1Q, c2Q} <= {r2, g2, b2};
    end
  end

  assign color_o = '{valid: valid3, mode: mode3, c0: c0Q, c1: c1Q, c2: c2Q};

endmodule

`default_nettype wire

// File: design/n64VideoDemux.sv
////////////////////
// N64 video bus demultiplexer
// Collects the sync nibble and the R, G and B words
// of the 4-cycle console bus into one pixel struct
////////////////////

`timescale 1ns/1ns
`default_nettype none

module n64VideoDemux #(
  parameter int colorWidthI = n64advPkg::ColorWidthI
) (
  input  logic                   VCLK_i,
  input  logic                   reset_i,
  input  logic                   nVdsync_i,
  input  logic [colorWidthI-1:0] vd_i,
  output n64advPkg::pixIn_t      pix_o
);

  import n64advPkg::*;

  // Bus phase, doubles as the 2-bit phase counter
  typedef enum logic [1:0] {
    PH_WAIT = 2'd0,
    PH_R    = 2'd1,
    PH_G    = 2'd2,
    PH_B    = 2'd3
  } phase_e;

  phase_e                 phase;
  logic                   validQ;
  syncBits_t              syncQ;
  logic [colorWidthI-1:0] rQ;
  logic [colorWidthI-1:0] gQ;
  logic [colorWidthI-1:0] bQ;

  ////////////////////
  // Phase control
  ////////////////////

  // Sync cycle restarts the count, a partial pixel is dropped
  always_ff @(posedge VCLK_i) begin
    if (reset_i) begin
      phase  <= PH_WAIT;
      validQ <= 1'b0;
    end else begin
      validQ <= 1'b0;
      if (!nVdsync_i) begin
        phase <= PH_R;
      end else begin
        case (phase)
          PH_R:    phase <= PH_G;
          PH_G:    phase <= PH_B;
          // B sampled here, pixel complete
          PH_B: begin
            phase  <= PH_WAIT;
            validQ <= 1'b1;
          end
          default: phase <= PH_WAIT;
        endcase
      end
    end
  end

  // Payload capture, one word per phase
  always_ff @(posedge VCLK_i) begin
    if (!nVdsync_i) begin
      syncQ <= syncBits_t'(vd_i[3:0]);
    end else begin
      case (phase)
        PH_R:    rQ <= vd_i;
        PH_G:    gQ <= vd_i;
        PH_B:    bQ <= vd_i;
        default: ;
      endcase
    end
  end

  assign pix_o = '{valid: validQ, sync: syncQ, r: rQ, g: gQ, b: bQ};

  // Valid pixel implies a sync cycle four edges earlier
  assert property (@(posedge VCLK_i) disable iff (reset_i)
    pix_o.valid |-> $past(!nVdsync_i, 4));

endmodule

`default_nettype wire

// File: design/n64advPkg.sv
////////////////////
// N64 video path shared definitions
// Widths of the console bus and the DAC channels,
// the pixel and sync structs and the output mode enum
////////////////////

`default_nettype none

package n64advPkg;

  ////////////////////
  // Widths
  ////////////////////

  // Colour word on the console bus
  localparam int ColorWidthI = 7;

  // One ADV712x channel
  localparam int ColorWidthO = 8;

  ////////////////////
  // Output mode
  ////////////////////

  // Decoded from the jumpers, YPbPr beats RGsB beats RGB
  typedef enum logic [1:0] {
    OUT_RGB   = 2'd0,
    OUT_RGSB  = 2'd1,
    OUT_YPBPR = 2'd2
  } outMode_e;

  ////////////////////
  // Pixel structs
  ////////////////////

  // Sync nibble, same bit order as vd_i[3:0]
  typedef struct packed {
    logic nVsync;
    logic nClamp;
    logic nHsync;
    logic nCsync;
  } syncBits_t;

  // One demultiplexed console pixel (26 bits)
  typedef struct packed {
    logic                   valid;
    syncBits_t              sync;
    logic [ColorWidthI-1:0] r;
    logic [ColorWidthI-1:0] g;
    logic [ColorWidthI-1:0] b;
  } pixIn_t;

  // Colour path result, channels in DAC order (27 bits)
  typedef struct packed {
    logic                   valid;
    outMode_e               mode;
    logic [ColorWidthO-1:0] c0;
    logic [ColorWidthO-1:0] c1;
    logic [ColorWidthO-1:0] c2;
  } colorPix_t;

  // Sync path result, pins already selected (4 bits)
  typedef struct packed {
    logic valid;
    logic nCsync;
    logic nHsyncOrF1;
    logic nVsyncOrF2;
  } syncOut_t;

endpackage

`default_nettype wire
